//--- verilog.f
design/isaPkg.sv
design/pipePkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/rvCore.sv
tests/memoryModel.sv
tests/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/coreTb.sv
//--------------------------------------------------------------------------
// Testbench for the pipelined core. Builds a program from LFSR constants,
// models the expected register values and checks every store in order.
//--------------------------------------------------------------------------
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] bootPc = 32'h0000_0040;
    localparam logic [31:0] dataBase = 32'h0000_0100;
    localparam logic [31:0] markerAddr = 32'h0000_03fc;
    localparam int cycleLimit = 60 * 4 * 4 + 40; // 60 instructions, 4 cycles, 4x margin

    logic clk, rst_n;
    logic [31:0] imemAddr, imemData, dmemAddr, dmemWriteData, dmemReadData;
    logic dmemWrite, dmemRead;

    logic [31:0] lfsrState, pcNext, expA, expD;
    logic [31:0] model [32];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    string expName [$];
    string nameNow;
    int valueErrors, otherErrors, cycleCount;

    rvCore #(.resetPc(bootPc)) dut_i (.*);
    memoryModel mem_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem_i.imem[pcNext[9:2]] = w;
        pcNext = pcNext + 32'd4;
    endtask

    task automatic opR(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                       input int rs1, input int rs2, input logic [31:0] value);
        emit({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), isaPkg::opOp});
        model[rd] = value;
    endtask

    task automatic opI(input logic [2:0] f3, input int rd, input int rs1,
                       input logic [11:0] imm, input logic [31:0] value);
        emit({imm, 5'(rs1), f3, 5'(rd), isaPkg::opOpImm});
        model[rd] = value;
    endtask

    // sw rs, slot*4(x1) and queue the expected store
    task automatic storeCheck(input int rs, input int slot, input string name);
        logic [11:0] off;
        off = 12'(slot * 4);
        emit({off[11:5], 5'(rs), 5'd1, 3'b010, off[4:0], isaPkg::opStore});
        expAddr.push_back(dataBase + 32'(slot * 4));
        expData.push_back(model[rs]);
        expName.push_back(name);
    endtask

    task automatic branch(input logic [2:0] f3, input int rs1, input int rs2,
                          input logic [12:0] off);
        emit({off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11],
              isaPkg::opBranch});
    endtask

    task automatic markerStores();
        for (int k = 0; k < 3; k++)
            emit({7'd0, 5'd0, 5'd25, 3'b010, 5'd0, isaPkg::opStore}); // sw x0,0(x25)
    endtask

    task automatic buildProgram();
        logic [31:0] a, b, c, u, jalPc;
        int lo, hi;
        for (int k = 0; k < 256; k++)
            mem_i.imem[k] = isaPkg::nopWord;
        for (int k = 0; k < 32; k++)
            model[k] = '0; // registers come out of reset as zero
        pcNext = bootPc;
        a = randBits(12);
        b = randBits(12);
        if (b == a)
            b = b ^ 32'd1; // BNE below needs distinct operands
        u = randBits(20) | 32'h8_0000;
        c = randBits(12);
        opI(isaPkg::f3Add, 1, 0, dataBase[11:0], dataBase);
        // back-to-back ALU chain
        opI(isaPkg::f3Add, 2, 0, a[11:0], sext12(a[11:0]));
        opI(isaPkg::f3Add, 3, 0, b[11:0], sext12(b[11:0]));
        opR(7'd0, isaPkg::f3Add, 4, 2, 3, model[2] + model[3]);
        opR(isaPkg::funct7Alt, isaPkg::f3Add, 5, 4, 2, model[4] - model[2]);
        opR(7'd0, isaPkg::f3And, 6, 5, 3, model[5] & model[3]);
        opR(7'd0, isaPkg::f3Or, 7, 6, 4, model[6] | model[4]);
        opR(7'd0, isaPkg::f3Xor, 8, 7, 5, model[7] ^ model[5]);
        opR(7'd0, isaPkg::f3Slt, 9, 8, 4, {31'd0, $signed(model[8]) < $signed(model[4])});
        opR(7'd0, isaPkg::f3Sll, 10, 4, 3, model[4] << model[3][4:0]);
        opR(7'd0, isaPkg::f3Srl, 11, 10, 2, model[10] >> model[2][4:0]);
        emit({u[19:0], 5'd13, isaPkg::opLui});
        model[13] = {u[19:0], 12'd0};
        opR(isaPkg::funct7Alt, isaPkg::f3Srl, 14, 13, 3,
            32'($signed(model[13]) >>> model[3][4:0]));
        opI(isaPkg::f3And, 15, 14, c[11:0], model[14] & sext12(c[11:0]));
        opI(isaPkg::f3Or, 16, 15, a[11:0], model[15] | sext12(a[11:0]));
        opI(isaPkg::f3Xor, 17, 16, b[11:0], model[16] ^ sext12(b[11:0]));
        opI(isaPkg::f3Slt, 18, 17, c[11:0],
            {31'd0, $signed(model[17]) < $signed(sext12(c[11:0]))});
        opI(isaPkg::f3Add, 19, 18, c[11:0], model[18] + sext12(c[11:0]));
        for (int r = 2; r < 20; r++)
            storeCheck(r, r - 2, $sformatf("alu x%0d", r));
        // load-use
        storeCheck(4, 32, "load source");
        emit({12'h080, 5'd1, 3'b010, 5'd20, isaPkg::opLoad});
        model[20] = model[4];
        opR(7'd0, isaPkg::f3Add, 21, 20, 3, model[20] + model[3]);
        storeCheck(21, 33, "load use");
        // taken branches skip the marker stores
        opI(isaPkg::f3Add, 25, 0, markerAddr[11:0], markerAddr);
        lo = ($signed(model[2]) < $signed(model[3])) ? 2 : 3;
        hi = 5 - lo;
        branch(isaPkg::f3Beq, 2, 2, 13'd16);
        markerStores();
        branch(isaPkg::f3Bne, 2, 3, 13'd16);
        markerStores();
        branch(isaPkg::f3Blt, lo, hi, 13'd16);
        markerStores();
        branch(isaPkg::f3Beq, 2, 3, 13'd8);
        storeCheck(2, 40, "beq not taken");
        branch(isaPkg::f3Bne, 2, 2, 13'd8);
        storeCheck(3, 41, "bne not taken");
        branch(isaPkg::f3Blt, hi, lo, 13'd8);
        storeCheck(4, 42, "blt not taken");
        // jal with link
        jalPc = pcNext;
        emit({1'b0, 10'd8, 1'b0, 8'd0, 5'd22, isaPkg::opJal}); // +16
        markerStores();
        model[22] = jalPc + 32'd4;
        storeCheck(22, 43, "jal link");
        emit({20'd0, 5'd0, isaPkg::opJal}); // spin here
    endtask

    // skipped stores must never reach memory
    markerNeverWritten: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmemWrite && dmemAddr == markerAddr))
        else begin
            otherErrors++;
            $display("a store that a branch or jump should skip wrote the marker address");
        end

    always @(posedge clk) begin
        if (!rst_n) begin
            assert (!dmemWrite && !dmemRead)
                else begin
                    otherErrors++;
                    $display("data memory strobe active during reset");
                end
        end else if (dmemWrite) begin
            if (expAddr.size() == 0) begin
                otherErrors++;
                $display("unexpected store to %h", dmemAddr);
            end else begin
                expA = expAddr.pop_front();
                expD = expData.pop_front();
                nameNow = expName.pop_front();
                assert (dmemAddr == expA)
                    else begin
                        valueErrors++;
                        $display("Error: %s address expected %h actual %h",
                                 nameNow, expA, dmemAddr);
                    end
                assert (dmemWriteData == expD)
                    else begin
                        valueErrors++;
                        $display("Error: %s data expected %h actual %h",
                                 nameNow, expD, dmemWriteData);
                    end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, %0d stores still expected",
                     cycleCount, expAddr.size());
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        cycleCount = 0;
        lfsrState = 32'hb499_d67c;
        buildProgram();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        assert (imemAddr == bootPc)
            else begin
                valueErrors++;
                $display("Error: reset pc expected %h actual %h", bootPc, imemAddr);
            end
        assert (!dmemWrite && !dmemRead)
            else begin
                otherErrors++;
                $display("data memory strobe active right after reset");
            end
        while (expAddr.size() != 0)
            @(negedge clk);
        repeat (8) @(negedge clk); // let any stray store show up
        $display("store value errors %0d, other errors %0d", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end
endmodule

//--- tests/memoryModel.sv
//--------------------------------------------------------------------------
// Synchronous instruction and data memories for the core testbench. The
// testbench writes the program into imem before reset is released.
//--------------------------------------------------------------------------
module memoryModel #(
    parameter int depthLog2 = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] imemAddr,
    output logic [31:0] imemData,
    input  logic [31:0] dmemAddr,
    input  logic [31:0] dmemWriteData,
    input  logic        dmemWrite,
    input  logic        dmemRead,
    output logic [31:0] dmemReadData
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] imem [2**depthLog2];
    logic [31:0] dmem [2**depthLog2];

    // one-cycle read latency on both ports
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imemData     <= '0;
            dmemReadData <= '0;
        end else begin
            imemData <= imem[imemAddr[depthLog2+1:2]];
            if (dmemRead)
                dmemReadData <= dmem[dmemAddr[depthLog2+1:2]];
        end
    end

    always @(posedge clk) begin
        if (dmemWrite)
            dmem[dmemAddr[depthLog2+1:2]] <= dmemWriteData; // word stores only
    end
endmodule

//--- design/rvCore.sv
//--------------------------------------------------------------------------
// Five-stage RV32I core top level. Wires the fetch, decode, execute and
// result stages to the instruction and data memory ports.
//--------------------------------------------------------------------------
module rvCore #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [isaPkg::xlen-1:0] imemAddr,
    input  logic [isaPkg::xlen-1:0] imemData,
    output logic [isaPkg::xlen-1:0] dmemAddr,
    output logic [isaPkg::xlen-1:0] dmemWriteData,
    output logic                    dmemWrite,
    output logic                    dmemRead,
    input  logic [isaPkg::xlen-1:0] dmemReadData
);
    // fetch and decode
    logic [isaPkg::xlen-1:0] fetchPc, fetchLink;
    logic                    fetchKill, stall;

    // decode/execute register
    logic [isaPkg::xlen-1:0]         dxPc, dxLink, dxRs1Data, dxRs2Data, dxImm;
    logic [isaPkg::regAddrWidth-1:0] dxRs1, dxRs2, dxRd;
    logic [pipePkg::aluOpWidth-1:0]  dxAluOp;
    logic [1:0]                      dxBrKind;
    logic dxSelPc, dxSelImm, dxJump, dxMemRead, dxMemWrite, dxRegWrite, dxWbFromMem;

    // execute/result register
    logic [isaPkg::xlen-1:0]         aluResult, storeData, branchTarget, exLink;
    logic [isaPkg::regAddrWidth-1:0] exRd;
    logic exBranch, exJump, exMemRead, exMemWrite, exRegWrite, exWbFromMem;

    // back from the result stage
    logic                            redirect, flush, resWrite, wbWrite;
    logic [isaPkg::xlen-1:0]         redirectTarget, resValue, wbData;
    logic [isaPkg::regAddrWidth-1:0] resRd, wbRd;

    fetchStage #(
        .resetPc (resetPc)
    ) fetch_i (.*);

    decodeStage decode_i (.*);

    executeStage execute_i (.*);

    resultStage result_i (.*);
endmodule

//--- design/resultStage.sv
//--------------------------------------------------------------------------
// Result stage. Drives the data memory, resolves branches and jumps, and
// holds the writeback register whose output feeds the register file.
//--------------------------------------------------------------------------
module resultStage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [isaPkg::xlen-1:0]         aluResult,
    input  logic [isaPkg::xlen-1:0]         storeData,
    input  logic [isaPkg::xlen-1:0]         branchTarget,
    input  logic [isaPkg::regAddrWidth-1:0] exRd,
    input  logic                            exBranch,
    input  logic                            exJump,
    input  logic                            exMemRead,
    input  logic                            exMemWrite,
    input  logic                            exRegWrite,
    input  logic                            exWbFromMem,
    input  logic [isaPkg::xlen-1:0]         exLink,
    input  logic [isaPkg::xlen-1:0]         dmemReadData,
    output logic [isaPkg::xlen-1:0]         dmemAddr,
    output logic [isaPkg::xlen-1:0]         dmemWriteData,
    output logic                            dmemWrite,
    output logic                            dmemRead,
    output logic                            redirect,
    output logic [isaPkg::xlen-1:0]         redirectTarget,
    output logic                            flush,
    output logic [isaPkg::regAddrWidth-1:0] resRd,
    output logic                            resWrite,
    output logic [isaPkg::xlen-1:0]         resValue,
    output logic [isaPkg::regAddrWidth-1:0] wbRd,
    output logic                            wbWrite,
    output logic [isaPkg::xlen-1:0]         wbData
);
    logic [isaPkg::xlen-1:0] wbAlu, wbLink;
    logic                    wbFromMem, wbIsLink;

    assign dmemAddr      = aluResult;
    assign dmemWriteData = storeData;
    assign dmemWrite     = exMemWrite;
    assign dmemRead      = exMemRead;

    assign redirect       = exJump | (exBranch & aluResult[0]);
    assign redirectTarget = branchTarget;
    assign flush          = redirect; // kills decode and execute

    // forwarding taps
    assign resRd    = exRd;
    assign resWrite = exRegWrite;
    assign resValue = aluResult;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {wbWrite, wbFromMem, wbIsLink} <= '0;
        end else begin
            wbWrite   <= exRegWrite;
            wbFromMem <= exWbFromMem;
            wbIsLink  <= exJump;
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= exRd;
        wbAlu  <= aluResult;
        wbLink <= exLink;
    end

    // load data arrives one cycle after dmemRead
    assign wbData = wbFromMem ? dmemReadData : (wbIsLink ? wbLink : wbAlu);
endmodule

//--- design/executeStage.sv
//--------------------------------------------------------------------------
// Execute stage. Forwards operands from the result and writeback stages,
// runs the ALU and branch compare, and fills the execute/result register.
//--------------------------------------------------------------------------
module executeStage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [isaPkg::xlen-1:0]         dxPc,
    input  logic [isaPkg::xlen-1:0]         dxLink,
    input  logic [isaPkg::xlen-1:0]         dxRs1Data,
    input  logic [isaPkg::xlen-1:0]         dxRs2Data,
    input  logic [isaPkg::xlen-1:0]         dxImm,
    input  logic [isaPkg::regAddrWidth-1:0] dxRs1,
    input  logic [isaPkg::regAddrWidth-1:0] dxRs2,
    input  logic [isaPkg::regAddrWidth-1:0] dxRd,
    input  logic [pipePkg::aluOpWidth-1:0]  dxAluOp,
    input  logic                            dxSelPc,
    input  logic                            dxSelImm,
    input  logic [1:0]                      dxBrKind,
    input  logic                            dxJump,
    input  logic                            dxMemRead,
    input  logic                            dxMemWrite,
    input  logic                            dxRegWrite,
    input  logic                            dxWbFromMem,
    input  logic                            flush,
    input  logic [isaPkg::regAddrWidth-1:0] resRd,
    input  logic                            resWrite,
    input  logic [isaPkg::xlen-1:0]         resValue,
    input  logic [isaPkg::regAddrWidth-1:0] wbRd,
    input  logic                            wbWrite,
    input  logic [isaPkg::xlen-1:0]         wbData,
    output logic [isaPkg::xlen-1:0]         aluResult,
    output logic [isaPkg::xlen-1:0]         storeData,
    output logic [isaPkg::xlen-1:0]         branchTarget,
    output logic [isaPkg::regAddrWidth-1:0] exRd,
    output logic                            exBranch,
    output logic                            exJump,
    output logic                            exMemRead,
    output logic                            exMemWrite,
    output logic                            exRegWrite,
    output logic                            exWbFromMem,
    output logic [isaPkg::xlen-1:0]         exLink
);
    logic [1:0]              fwdA, fwdB;
    logic [isaPkg::xlen-1:0] rs1Val, rs2Val, opA, opB, aluOut;
    logic                    cond;

    // result stage is younger, so it wins
    function automatic logic [1:0] fwdSel(input logic [isaPkg::regAddrWidth-1:0] rs);
        if (resWrite && resRd != '0 && resRd == rs)
            return pipePkg::fwdResult;
        else if (wbWrite && wbRd != '0 && wbRd == rs)
            return pipePkg::fwdWriteback;
        return pipePkg::fwdNone;
    endfunction

    function automatic logic [isaPkg::xlen-1:0] fwdMux(input logic [1:0] sel,
                                                       input logic [isaPkg::xlen-1:0] regVal);
        case (sel)
            pipePkg::fwdResult:    return resValue;
            pipePkg::fwdWriteback: return wbData;
            default:               return regVal;
        endcase
    endfunction

    always_comb begin
        fwdA   = fwdSel(dxRs1);
        fwdB   = fwdSel(dxRs2);
        rs1Val = fwdMux(fwdA, dxRs1Data);
        rs2Val = fwdMux(fwdB, dxRs2Data);
        opA    = dxSelPc ? dxPc : rs1Val;
        opB    = dxSelImm ? dxImm : rs2Val;
    end

    always_comb begin
        case (dxAluOp)
            pipePkg::aluSub:   aluOut = opA - opB;
            pipePkg::aluAnd:   aluOut = opA & opB;
            pipePkg::aluOr:    aluOut = opA | opB;
            pipePkg::aluXor:   aluOut = opA ^ opB;
            pipePkg::aluSlt:   aluOut = {{(isaPkg::xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            pipePkg::aluSll:   aluOut = opA << opB[4:0];
            pipePkg::aluSrl:   aluOut = opA >> opB[4:0];
            pipePkg::aluSra:   aluOut = $signed(opA) >>> opB[4:0];
            pipePkg::aluPassB: aluOut = opB;
            default:           aluOut = opA + opB;
        endcase
        case (dxBrKind)
            pipePkg::brEq: cond = (aluOut == '0); // xor of the operands
            pipePkg::brNe: cond = (aluOut != '0);
            pipePkg::brLt: cond = aluOut[0];      // slt
            default:       cond = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {exBranch, exJump, exMemRead, exMemWrite, exRegWrite, exWbFromMem} <= '0;
        end else begin
            exBranch    <= (dxBrKind != pipePkg::brNone) & ~flush;
            exJump      <= dxJump & ~flush;
            exMemRead   <= dxMemRead & ~flush;
            exMemWrite  <= dxMemWrite & ~flush;
            exRegWrite  <= dxRegWrite & ~flush;
            exWbFromMem <= dxWbFromMem & ~flush;
        end
    end

    // branch condition rides in bit 0
    always_ff @(posedge clk) begin
        aluResult    <= (dxBrKind != pipePkg::brNone) ? {{(isaPkg::xlen-1){1'b0}}, cond} : aluOut;
        storeData    <= rs2Val;
        branchTarget <= dxPc + dxImm;
        exRd         <= dxRd;
        exLink       <= dxLink;
    end
endmodule

//--- design/decodeStage.sv
//--------------------------------------------------------------------------
// Decode stage. Decodes control and immediate, reads the register file,
// detects load-use hazards and fills the decode/execute register.
//--------------------------------------------------------------------------
module decodeStage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [isaPkg::xlen-1:0]           imemData,
    input  logic [isaPkg::xlen-1:0]           fetchPc,
    input  logic [isaPkg::xlen-1:0]           fetchLink,
    input  logic                              fetchKill,
    input  logic                              flush,
    input  logic [isaPkg::regAddrWidth-1:0]   wbRd,
    input  logic [isaPkg::xlen-1:0]           wbData,
    input  logic                              wbWrite,
    output logic                              stall,
    output logic [isaPkg::xlen-1:0]           dxPc,
    output logic [isaPkg::xlen-1:0]           dxLink,
    output logic [isaPkg::xlen-1:0]           dxRs1Data,
    output logic [isaPkg::xlen-1:0]           dxRs2Data,
    output logic [isaPkg::xlen-1:0]           dxImm,
    output logic [isaPkg::regAddrWidth-1:0]   dxRs1,
    output logic [isaPkg::regAddrWidth-1:0]   dxRs2,
    output logic [isaPkg::regAddrWidth-1:0]   dxRd,
    output logic [pipePkg::aluOpWidth-1:0]    dxAluOp,
    output logic                              dxSelPc,
    output logic                              dxSelImm,
    output logic [1:0]                        dxBrKind,
    output logic                              dxJump,
    output logic                              dxMemRead,
    output logic                              dxMemWrite,
    output logic                              dxRegWrite,
    output logic                              dxWbFromMem
);
    isaPkg::instrWord              ins;
    logic [isaPkg::xlen-1:0]       rs1Data, rs2Data, imm;
    logic [pipePkg::aluOpWidth-1:0] aluOp;
    logic [1:0]                    brKind;
    logic selPc, selImm, jump, memRead, memWrite, regWrite, wbFromMem;
    logic altOp, bubble;

    assign ins   = fetchKill ? isaPkg::nopWord : imemData;
    assign altOp = (ins.r.opcode == isaPkg::opOp) && (ins.r.funct7 == isaPkg::funct7Alt);

    always_comb begin
        aluOp = pipePkg::aluAdd;
        brKind = pipePkg::brNone;
        {selPc, selImm, jump, memRead, memWrite, regWrite, wbFromMem} = '0;
        imm = {{20{ins[31]}}, ins.i.imm}; // I-type unless overridden
        case (ins.r.opcode)
            isaPkg::opOp, isaPkg::opOpImm: begin
                regWrite = 1'b1;
                selImm   = (ins.r.opcode == isaPkg::opOpImm);
                case (ins.r.funct3)
                    isaPkg::f3Add: aluOp = altOp ? pipePkg::aluSub : pipePkg::aluAdd;
                    isaPkg::f3Sll: aluOp = pipePkg::aluSll;
                    isaPkg::f3Slt: aluOp = pipePkg::aluSlt;
                    isaPkg::f3Xor: aluOp = pipePkg::aluXor;
                    isaPkg::f3Srl: aluOp = altOp ? pipePkg::aluSra : pipePkg::aluSrl;
                    isaPkg::f3Or:  aluOp = pipePkg::aluOr;
                    isaPkg::f3And: aluOp = pipePkg::aluAnd;
                    default:       aluOp = pipePkg::aluAdd;
                endcase
            end
            isaPkg::opLui: begin
                {regWrite, selImm} = 2'b11;
                aluOp = pipePkg::aluPassB;
                imm   = {ins[31:12], 12'b0};
            end
            isaPkg::opLoad: begin
                {regWrite, selImm, memRead, wbFromMem} = 4'b1111;
            end
            isaPkg::opStore: begin
                {selImm, memWrite} = 2'b11;
                imm = {{20{ins[31]}}, ins.i.imm[11:5], ins.i.rd}; // split S immediate
            end
            isaPkg::opBranch: begin
                imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                aluOp = (ins.r.funct3 == isaPkg::f3Blt) ? pipePkg::aluSlt : pipePkg::aluXor;
                case (ins.r.funct3)
                    isaPkg::f3Beq: brKind = pipePkg::brEq;
                    isaPkg::f3Bne: brKind = pipePkg::brNe;
                    isaPkg::f3Blt: brKind = pipePkg::brLt;
                    default:       brKind = pipePkg::brNone;
                endcase
            end
            isaPkg::opJal: begin
                {regWrite, jump, selPc, selImm} = 4'b1111; // ALU mirrors the target
                imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // load in execute feeding this instruction
    assign stall  = dxMemRead && (dxRd != '0) && (dxRd == ins.r.rs1 || dxRd == ins.r.rs2);
    assign bubble = stall | flush;

    regFile rf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (ins.r.rs1),
        .rs2     (ins.r.rs2),
        .wbRd    (wbRd),
        .wbData  (wbData),
        .wbWrite (wbWrite),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dxBrKind <= pipePkg::brNone;
            {dxJump, dxMemRead, dxMemWrite, dxRegWrite, dxWbFromMem} <= '0;
        end else begin
            dxBrKind    <= bubble ? pipePkg::brNone : brKind;
            dxJump      <= jump & ~bubble;
            dxMemRead   <= memRead & ~bubble;
            dxMemWrite  <= memWrite & ~bubble;
            dxRegWrite  <= regWrite & ~bubble;
            dxWbFromMem <= wbFromMem & ~bubble;
        end
    end

    always_ff @(posedge clk) begin
        dxPc      <= fetchPc;
        dxLink    <= fetchLink;
        dxRs1Data <= rs1Data;
        dxRs2Data <= rs2Data;
        dxImm     <= imm;
        dxRs1     <= ins.r.rs1;
        dxRs2     <= ins.r.rs2;
        dxRd      <= ins.r.rd;
        dxAluOp   <= aluOp;
        dxSelPc   <= selPc;
        dxSelImm  <= selImm;
    end
endmodule

//--- design/regFile.sv
//--------------------------------------------------------------------------
// 32-entry integer register file, two read ports and one write port.
// A read of the register being written returns the new value.
//--------------------------------------------------------------------------
module regFile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [isaPkg::regAddrWidth-1:0] rs1,
    input  logic [isaPkg::regAddrWidth-1:0] rs2,
    input  logic [isaPkg::regAddrWidth-1:0] wbRd,
    input  logic [isaPkg::xlen-1:0]         wbData,
    input  logic                            wbWrite,
    output logic [isaPkg::xlen-1:0]         rs1Data,
    output logic [isaPkg::xlen-1:0]         rs2Data
);
    logic [isaPkg::xlen-1:0] regs [2**isaPkg::regAddrWidth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 2**isaPkg::regAddrWidth; k++)
                regs[k] <= '0;
        end else if (wbWrite && wbRd != '0) begin
            regs[wbRd] <= wbData; // x0 never written
        end
    end

    // write-first bypass
    assign rs1Data = (rs1 == '0) ? '0 :
                     (wbWrite && wbRd == rs1) ? wbData : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 :
                     (wbWrite && wbRd == rs2) ? wbData : regs[rs2];
endmodule

//--- design/fetchStage.sv
//--------------------------------------------------------------------------
// Fetch stage. Picks the next instruction address and registers the pc and
// link address of the word returned by the synchronous instruction memory.
//--------------------------------------------------------------------------
module fetchStage #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    redirect,
    input  logic [isaPkg::xlen-1:0] redirectTarget,
    output logic [isaPkg::xlen-1:0] imemAddr,
    output logic [isaPkg::xlen-1:0] fetchPc,
    output logic [isaPkg::xlen-1:0] fetchLink,
    output logic                    fetchKill
);
    logic killQ; // word on the bus after reset is stale

    // redirect wins over stall
    always_comb begin
        if (redirect)
            imemAddr = redirectTarget;
        else if (stall)
            imemAddr = fetchPc;   // re-read the word held in decode
        else
            imemAddr = fetchLink; // sequential pc
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetchPc   <= resetPc;
            fetchLink <= resetPc;
            killQ     <= 1'b1;
        end else begin
            fetchPc   <= imemAddr;
            fetchLink <= imemAddr + 32'd4;
            killQ     <= 1'b0;
        end
    end

    assign fetchKill = killQ | redirect; // wrong-path word dies with the redirect
endmodule

//--- design/pipePkg.sv
//--------------------------------------------------------------------------
// Pipeline-internal codes: ALU operations, branch kinds and forwarding
// selects passed between the decode and execute stages.
//--------------------------------------------------------------------------
package pipePkg;
    localparam int aluOpWidth = 4;

    localparam logic [aluOpWidth-1:0] aluAdd   = 4'd0;
    localparam logic [aluOpWidth-1:0] aluSub   = 4'd1;
    localparam logic [aluOpWidth-1:0] aluAnd   = 4'd2;
    localparam logic [aluOpWidth-1:0] aluOr    = 4'd3;
    localparam logic [aluOpWidth-1:0] aluXor   = 4'd4;
    localparam logic [aluOpWidth-1:0] aluSlt   = 4'd5;
    localparam logic [aluOpWidth-1:0] aluSll   = 4'd6;
    localparam logic [aluOpWidth-1:0] aluSrl   = 4'd7;
    localparam logic [aluOpWidth-1:0] aluSra   = 4'd8;
    localparam logic [aluOpWidth-1:0] aluPassB = 4'd9; // LUI

    // branch kind
    localparam logic [1:0] brNone = 2'd0;
    localparam logic [1:0] brEq   = 2'd1;
    localparam logic [1:0] brNe   = 2'd2;
    localparam logic [1:0] brLt   = 2'd3;

    // operand forwarding source
    localparam logic [1:0] fwdNone      = 2'd0;
    localparam logic [1:0] fwdResult    = 2'd1;
    localparam logic [1:0] fwdWriteback = 2'd2;
endpackage

//--- design/isaPkg.sv
//--------------------------------------------------------------------------
// RV32I subset encodings: opcodes, function codes and the instruction word
// with its R and I/S views. Referenced by scoped name from the decoder.
//--------------------------------------------------------------------------
package isaPkg;
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;

    // major opcodes
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;

    localparam logic [2:0] f3Add = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Srl = 3'b101; // SRL, SRA
    localparam logic [2:0] f3Or  = 3'b110;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;

    localparam logic [6:0] funct7Alt = 7'b0100000; // SUB, SRA
    localparam logic [31:0] nopWord = 32'h0000_0013; // addi x0,x0,0

    // one word, read either as R-type or as I/S-type
    typedef union packed {
        struct packed {
            logic [6:0]              funct7;
            logic [regAddrWidth-1:0] rs2;
            logic [regAddrWidth-1:0] rs1;
            logic [2:0]              funct3;
            logic [regAddrWidth-1:0] rd;
            logic [6:0]              opcode;
        } r;
        struct packed {
            logic [11:0]             imm;    // S keeps imm[11:5] in the top bits
            logic [regAddrWidth-1:0] rs1;
            logic [2:0]              funct3;
            logic [regAddrWidth-1:0] rd;     // S imm[4:0]
            logic [6:0]              opcode;
        } i;
    } instrWord;
endpackage
